//--- include/soc_config.svh
// System controller core configuration
// Bus widths, CSR map, register indices and reset timing
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// Bus widths
`define SOC_DATA_W           32
`define SOC_CSR_ADDR_W       15
`define SOC_CSR_BANK_W       5
`define SOC_CSR_REG_W        10

// CSR bank of the system controller
`define SOC_SYSCTL_BANK      1

// Three buttons below four PCB revision straps
`define SOC_GPIO_IN_W        7
`define SOC_GPIO_OUT_W       2

`define SOC_SYSTEM_ID        32'h10004D31

// Reset timing in sys_clk cycles, board value is about one million
`define SOC_RST_HOLD_CYCLES  200
`define SOC_FLASH_RST_CYCLES 128

// Register indices inside the bank
`define SOC_REG_SYSTEM_ID     0
`define SOC_REG_GPIO_IN       1
`define SOC_REG_GPIO_OUT      2
`define SOC_REG_GPIO_IRQ_EN   3
`define SOC_REG_GPIO_IRQ_PEND 4
`define SOC_REG_TIMER_CTRL    5
`define SOC_REG_TIMER_COMPARE 6
`define SOC_REG_TIMER_COUNTER 7
`define SOC_REG_HARD_RESET    8

// Timer control bits
`define SOC_TCTRL_EN   0
`define SOC_TCTRL_AUTO 1
`define SOC_TCTRL_PEND 2

`endif

//--- src/soc_csr_pkg.sv
// CSR bus types
// Data word and the address word with its bank/register view
`include "soc_config.svh"

package soc_csr_pkg;

	// One CSR data word
	typedef logic [`SOC_DATA_W-1:0] csr_word_t;

	// One CSR address
	// Bridge fills the raw word index, slaves decode bank and register
	typedef union packed {
		logic [`SOC_CSR_ADDR_W-1:0] raw;
		struct packed {
			logic [`SOC_CSR_BANK_W-1:0] bank;
			logic [`SOC_CSR_REG_W-1:0]  index;
		} sel;
	} csr_addr_u;

endpackage

//--- src/soc_sysctl_pkg.sv
// System controller word types
// GPIO input and output vectors, timer word
`include "soc_config.svh"

package soc_sysctl_pkg;

	// Buttons and revision straps
	typedef logic [`SOC_GPIO_IN_W-1:0] gpio_in_t;

	// LEDs
	typedef logic [`SOC_GPIO_OUT_W-1:0] gpio_out_t;

	// Counter and compare value
	typedef logic [`SOC_DATA_W-1:0] timer_word_t;

endpackage

//--- src/reset_sequencer.sv
// Reset sequencer
// Holds system reset for a counted time, releases flash reset earlier
`timescale 1ns/1ps
`include "soc_config.svh"

module reset_sequencer (
	input  logic       sys_clk,
	input  logic       trigger_reset,
	input  logic [2:0] btn_i,
	input  logic       hard_reset_i,
	output logic       sys_rst_o,
	output logic       flash_rst_n_o
);

	localparam int HOLD_W  = $clog2(`SOC_RST_HOLD_CYCLES + 1);
	localparam int FLASH_W = $clog2(`SOC_FLASH_RST_CYCLES + 1);

	logic               rst_req;
	logic [HOLD_W-1:0]  hold_cnt;
	logic [FLASH_W-1:0] flash_cnt;

	// Request from external reset, three-button chord or software
	always_ff @(posedge sys_clk) begin
		rst_req <= trigger_reset | (&btn_i) | hard_reset_i;
	end

	// ----------------------------------------------------------
	// System reset hold
	// ----------------------------------------------------------
	// Reload while requested, then count down to zero
	always_ff @(posedge sys_clk) begin
		if (rst_req) begin
			hold_cnt <= HOLD_W'(`SOC_RST_HOLD_CYCLES);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
		// One more stage so release lands one cycle after zero
		sys_rst_o <= (hold_cnt != '0);
	end

	// ----------------------------------------------------------
	// Flash reset release
	// ----------------------------------------------------------
	// Flash needs time out of reset before the first fetch
	always_ff @(posedge sys_clk) begin
		if (rst_req) begin
			flash_cnt <= '0;
		end else if (!flash_rst_n_o) begin
			flash_cnt <= flash_cnt + 1'b1;
		end
	end

	assign flash_rst_n_o = (flash_cnt == FLASH_W'(`SOC_FLASH_RST_CYCLES));

	// Flash must already be out of reset when the system starts
	a_flash_first: assert property (@(posedge sys_clk)
		$fell(sys_rst_o) |-> flash_rst_n_o)
		else $error("system reset released while flash still in reset");

endmodule

//--- src/wb_csr_bridge.sv
// Wishbone to CSR bridge
// Turns one classic Wishbone cycle into one CSR access with ack
`timescale 1ns/1ps
`include "soc_config.svh"

module wb_csr_bridge (
	input  logic                    sys_clk,
	input  logic                    sys_rst_i,
	input  logic [`SOC_DATA_W-1:0]  wb_adr_i,
	input  soc_csr_pkg::csr_word_t  wb_dat_i,
	input  logic                    wb_we_i,
	input  logic                    wb_cyc_i,
	input  logic                    wb_stb_i,
	input  soc_csr_pkg::csr_word_t  csr_dr_i,
	output soc_csr_pkg::csr_word_t  wb_dat_o,
	output logic                    wb_ack_o,
	output soc_csr_pkg::csr_addr_u  csr_a_o,
	output logic                    csr_we_o,
	output soc_csr_pkg::csr_word_t  csr_dw_o
);

	// Sequencer states
	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_WAIT = 2'd1;
	localparam logic [1:0] S_ACK  = 2'd2;

	logic [1:0] state;

	// ----------------------------------------------------------
	// Access sequencer
	// ----------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state    <= S_IDLE;
			wb_ack_o <= 1'b0;
			csr_we_o <= 1'b0;
			csr_a_o  <= '0;
		end else begin
			// Ack is a single-cycle pulse
			wb_ack_o <= 1'b0;
			case (state)
				S_IDLE: begin
					// Strobe still high during ack cycle, skip it
					if (wb_cyc_i && wb_stb_i && !wb_ack_o) begin
						// Byte address to word index
						csr_a_o.raw <= wb_adr_i[`SOC_CSR_ADDR_W+1:2];
						csr_we_o    <= wb_we_i;
						state       <= S_WAIT;
					end
				end
				S_WAIT: begin
					// Address valid for one cycle only
					csr_a_o  <= '0;
					csr_we_o <= 1'b0;
					state    <= S_ACK;
				end
				S_ACK: begin
					// Slave read data registered by now
					wb_ack_o <= 1'b1;
					state    <= S_IDLE;
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// Payload capture
	always_ff @(posedge sys_clk) begin
		if (state == S_IDLE) begin
			csr_dw_o <= wb_dat_i;
		end
		if (state == S_ACK) begin
			wb_dat_o <= csr_dr_i;
		end
	end

	a_ack_single: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		wb_ack_o |=> !wb_ack_o)
		else $error("Wishbone ack held for two cycles");

	// CSR write only after a Wishbone write strobe
	a_we_from_bus: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		csr_we_o |-> $past(wb_cyc_i && wb_stb_i && wb_we_i))
		else $error("CSR write without a bus write");

endmodule

//--- src/gpio_input_sync.sv
// GPIO input synchronizer
// Two-stage sync of buttons and straps with per-bit change flags
`timescale 1ns/1ps

module gpio_input_sync (
	input  logic                     sys_clk,
	input  logic                     sys_rst_i,
	input  soc_sysctl_pkg::gpio_in_t gpio_i,
	output soc_sysctl_pkg::gpio_in_t gpio_sync_o,
	output soc_sysctl_pkg::gpio_in_t gpio_change_o
);

	soc_sysctl_pkg::gpio_in_t sync1;
	soc_sysctl_pkg::gpio_in_t sync2;

	// Metastability stages, free running
	always_ff @(posedge sys_clk) begin
		sync1 <= gpio_i;
		sync2 <= sync1;
	end

	// History stage doubles as the visible input value
	always_ff @(posedge sys_clk) begin
		gpio_sync_o <= sync2;
		if (sys_rst_i) begin
			// Track pins quietly so straps raise no flag
			gpio_change_o <= '0;
		end else begin
			gpio_change_o <= sync2 ^ gpio_sync_o;
		end
	end

endmodule

//--- src/sysctl_timer.sv
// Compare timer
// Free counter with load, compare match and optional auto-restart
`timescale 1ns/1ps

module sysctl_timer (
	input  logic                        sys_clk,
	input  logic                        sys_rst_i,
	input  logic                        en_i,
	input  logic                        auto_i,
	input  soc_sysctl_pkg::timer_word_t compare_i,
	input  logic                        load_i,
	input  soc_sysctl_pkg::timer_word_t load_val_i,
	output soc_sysctl_pkg::timer_word_t count_o,
	output logic                        match_o
);

	// Match only counts while running
	assign match_o = en_i && (count_o == compare_i);

	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			count_o <= '0;
		end else if (load_i) begin
			// Software load beats counting
			count_o <= load_val_i;
		end else if (en_i) begin
			if (match_o) begin
				// One-shot parks on compare value
				if (auto_i) begin
					count_o <= '0;
				end
			end else begin
				count_o <= count_o + 1'b1;
			end
		end
	end

	// Register block drops enable right after a one-shot match
	a_oneshot_single: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		(match_o && !auto_i) |=> !match_o)
		else $error("one-shot match lasted two cycles");

endmodule

//--- src/sysctl_regs.sv
// System controller register block
// GPIO, timer control and hard reset registers on one CSR bank
`timescale 1ns/1ps
`include "soc_config.svh"

module sysctl_regs (
	input  logic                        sys_clk,
	input  logic                        sys_rst_i,
	input  soc_csr_pkg::csr_addr_u      csr_a_i,
	input  logic                        csr_we_i,
	input  soc_csr_pkg::csr_word_t      csr_dw_i,
	input  soc_sysctl_pkg::gpio_in_t    gpio_sync_i,
	input  soc_sysctl_pkg::gpio_in_t    gpio_change_i,
	input  soc_sysctl_pkg::timer_word_t timer_count_i,
	input  logic                        timer_match_i,
	output soc_csr_pkg::csr_word_t      csr_dr_o,
	output soc_sysctl_pkg::gpio_out_t   led_o,
	output logic                        gpio_irq_o,
	output logic                        timer_irq_o,
	output logic                        timer_en_o,
	output logic                        timer_auto_o,
	output soc_sysctl_pkg::timer_word_t timer_compare_o,
	output logic                        timer_load_o,
	output soc_sysctl_pkg::timer_word_t timer_load_val_o,
	output logic                        hard_reset_o
);

	logic                     hit;
	logic                     wr;
	soc_sysctl_pkg::gpio_in_t irq_en;
	soc_sysctl_pkg::gpio_in_t irq_pend;
	soc_sysctl_pkg::gpio_in_t pend_clr;
	logic                     tmr_pend;
	logic                     tmr_clr;
	soc_csr_pkg::csr_word_t   tctrl_word;

	// ----------------------------------------------------------
	// Bank decode
	// ----------------------------------------------------------
	assign hit = (csr_a_i.sel.bank == `SOC_CSR_BANK_W'(`SOC_SYSCTL_BANK));
	assign wr  = hit && csr_we_i;

	// Write-one-clear masks
	assign pend_clr = (wr && csr_a_i.sel.index == `SOC_REG_GPIO_IRQ_PEND)
		? csr_dw_i[`SOC_GPIO_IN_W-1:0] : '0;
	assign tmr_clr  = wr && (csr_a_i.sel.index == `SOC_REG_TIMER_CTRL)
		&& csr_dw_i[`SOC_TCTRL_PEND];

	// Counter load straight from the bus
	assign timer_load_o     = wr && (csr_a_i.sel.index == `SOC_REG_TIMER_COUNTER);
	assign timer_load_val_o = csr_dw_i;

	// ----------------------------------------------------------
	// Registers
	// ----------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			led_o           <= '0;
			irq_en          <= '0;
			irq_pend        <= '0;
			timer_en_o      <= 1'b0;
			timer_auto_o    <= 1'b0;
			tmr_pend        <= 1'b0;
			timer_compare_o <= '0;
			hard_reset_o    <= 1'b0;
		end else begin
			// Set wins over a same-cycle clear
			irq_pend <= (irq_pend & ~pend_clr) | (gpio_change_i & irq_en);
			tmr_pend <= (tmr_pend & ~tmr_clr) | timer_match_i;
			// Any write value triggers the pulse
			hard_reset_o <= wr && (csr_a_i.sel.index == `SOC_REG_HARD_RESET);
			if (wr) begin
				case (csr_a_i.sel.index)
					`SOC_REG_GPIO_OUT:      led_o <= csr_dw_i[`SOC_GPIO_OUT_W-1:0];
					`SOC_REG_GPIO_IRQ_EN:   irq_en <= csr_dw_i[`SOC_GPIO_IN_W-1:0];
					`SOC_REG_TIMER_CTRL: begin
						timer_en_o   <= csr_dw_i[`SOC_TCTRL_EN];
						timer_auto_o <= csr_dw_i[`SOC_TCTRL_AUTO];
					end
					`SOC_REG_TIMER_COMPARE: timer_compare_o <= csr_dw_i;
					default: ;
				endcase
			end
			// One-shot stops itself on match
			if (timer_match_i && !timer_auto_o) begin
				timer_en_o <= 1'b0;
			end
		end
	end

	// Control word as software sees it
	always_comb begin
		tctrl_word                  = '0;
		tctrl_word[`SOC_TCTRL_EN]   = timer_en_o;
		tctrl_word[`SOC_TCTRL_AUTO] = timer_auto_o;
		tctrl_word[`SOC_TCTRL_PEND] = tmr_pend;
	end

	// ----------------------------------------------------------
	// Read data, zero when not addressed
	// ----------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		csr_dr_o <= '0;
		if (hit && !csr_we_i) begin
			case (csr_a_i.sel.index)
				`SOC_REG_SYSTEM_ID:     csr_dr_o <= `SOC_SYSTEM_ID;
				`SOC_REG_GPIO_IN:       csr_dr_o <= soc_csr_pkg::csr_word_t'(gpio_sync_i);
				`SOC_REG_GPIO_OUT:      csr_dr_o <= soc_csr_pkg::csr_word_t'(led_o);
				`SOC_REG_GPIO_IRQ_EN:   csr_dr_o <= soc_csr_pkg::csr_word_t'(irq_en);
				`SOC_REG_GPIO_IRQ_PEND: csr_dr_o <= soc_csr_pkg::csr_word_t'(irq_pend);
				`SOC_REG_TIMER_CTRL:    csr_dr_o <= tctrl_word;
				`SOC_REG_TIMER_COMPARE: csr_dr_o <= timer_compare_o;
				`SOC_REG_TIMER_COUNTER: csr_dr_o <= timer_count_i;
				default: ;
			endcase
		end
	end

	// Interrupt lines
	assign gpio_irq_o  = |(irq_pend & irq_en);
	assign timer_irq_o = tmr_pend;

	// Bridge spacing keeps two writes apart
	a_hard_reset_pulse: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		hard_reset_o |=> !hard_reset_o)
		else $error("hard reset pulse longer than one cycle");

endmodule

//--- src/soc_top.sv
// Board control core top level
// Reset sequencer, Wishbone-to-CSR bridge and system controller
`timescale 1ns/1ps
`include "soc_config.svh"

module soc_top (
	input  logic                      sys_clk,
	input  logic                      trigger_reset,
	input  logic [`SOC_DATA_W-1:0]    wb_adr_i,
	input  soc_csr_pkg::csr_word_t    wb_dat_i,
	input  logic                      wb_we_i,
	input  logic                      wb_cyc_i,
	input  logic                      wb_stb_i,
	input  logic [2:0]                btn_i,
	input  logic [3:0]                pcb_revision_i,
	output soc_csr_pkg::csr_word_t    wb_dat_o,
	output logic                      wb_ack_o,
	output soc_sysctl_pkg::gpio_out_t led_o,
	output logic                      gpio_irq_o,
	output logic                      timer_irq_o,
	output logic                      flash_rst_n_o,
	output logic                      periph_rst_n_o
);

	logic                        sys_rst;
	logic                        hard_reset;
	soc_csr_pkg::csr_addr_u      csr_a;
	logic                        csr_we;
	soc_csr_pkg::csr_word_t      csr_dw;
	soc_csr_pkg::csr_word_t      csr_dr;
	soc_sysctl_pkg::gpio_in_t    gpio_sync;
	soc_sysctl_pkg::gpio_in_t    gpio_change;
	logic                        timer_en;
	logic                        timer_auto;
	logic                        timer_load;
	logic                        timer_match;
	soc_sysctl_pkg::timer_word_t timer_compare;
	soc_sysctl_pkg::timer_word_t timer_load_val;
	soc_sysctl_pkg::timer_word_t timer_count;

	// ----------------------------------------------------------
	// Clocking and reset
	// ----------------------------------------------------------
	reset_sequencer u_rst (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset),
		.btn_i         (btn_i),
		.hard_reset_i  (hard_reset),
		.sys_rst_o     (sys_rst),
		.flash_rst_n_o (flash_rst_n_o)
	);

	assign periph_rst_n_o = ~sys_rst;

	// Bus side
	wb_csr_bridge u_brg (
		.sys_clk   (sys_clk),
		.sys_rst_i (sys_rst),
		.wb_adr_i  (wb_adr_i),
		.wb_dat_i  (wb_dat_i),
		.wb_we_i   (wb_we_i),
		.wb_cyc_i  (wb_cyc_i),
		.wb_stb_i  (wb_stb_i),
		.csr_dr_i  (csr_dr),
		.wb_dat_o  (wb_dat_o),
		.wb_ack_o  (wb_ack_o),
		.csr_a_o   (csr_a),
		.csr_we_o  (csr_we),
		.csr_dw_o  (csr_dw)
	);

	// ----------------------------------------------------------
	// System controller
	// ----------------------------------------------------------
	// Revision straps sit above the buttons
	gpio_input_sync u_gpio (
		.sys_clk       (sys_clk),
		.sys_rst_i     (sys_rst),
		.gpio_i        ({pcb_revision_i, btn_i}),
		.gpio_sync_o   (gpio_sync),
		.gpio_change_o (gpio_change)
	);

	sysctl_timer u_timer (
		.sys_clk    (sys_clk),
		.sys_rst_i  (sys_rst),
		.en_i       (timer_en),
		.auto_i     (timer_auto),
		.compare_i  (timer_compare),
		.load_i     (timer_load),
		.load_val_i (timer_load_val),
		.count_o    (timer_count),
		.match_o    (timer_match)
	);

	sysctl_regs u_regs (
		.sys_clk          (sys_clk),
		.sys_rst_i        (sys_rst),
		.csr_a_i          (csr_a),
		.csr_we_i         (csr_we),
		.csr_dw_i         (csr_dw),
		.gpio_sync_i      (gpio_sync),
		.gpio_change_i    (gpio_change),
		.timer_count_i    (timer_count),
		.timer_match_i    (timer_match),
		.csr_dr_o         (csr_dr),
		.led_o            (led_o),
		.gpio_irq_o       (gpio_irq_o),
		.timer_irq_o      (timer_irq_o),
		.timer_en_o       (timer_en),
		.timer_auto_o     (timer_auto),
		.timer_compare_o  (timer_compare),
		.timer_load_o     (timer_load),
		.timer_load_val_o (timer_load_val),
		.hard_reset_o     (hard_reset)
	);

endmodule

//--- tb/tb_soc_top.sv
// Testbench for the board control core
// Runs stim file commands over Wishbone, checks registers, LEDs, IRQs and resets
`timescale 1ns/1ps
`include "soc_config.svh"

module tb_soc_top;

	localparam string STIM_FILE = "tb/soc_stim.txt";
	localparam int    HOLD      = `SOC_RST_HOLD_CYCLES;
	localparam int    SYS       = `SOC_SYSCTL_BANK;
	localparam int    ACK_LIMIT = 20;

	// Timer control words
	localparam soc_csr_pkg::csr_word_t T_EN   = 1 << `SOC_TCTRL_EN;
	localparam soc_csr_pkg::csr_word_t T_AUTO = 1 << `SOC_TCTRL_AUTO;
	localparam soc_csr_pkg::csr_word_t T_PEND = 1 << `SOC_TCTRL_PEND;

	logic                      sys_clk;
	logic                      trigger_reset;
	logic [`SOC_DATA_W-1:0]    wb_adr_i;
	soc_csr_pkg::csr_word_t    wb_dat_i;
	logic                      wb_we_i;
	logic                      wb_cyc_i;
	logic                      wb_stb_i;
	logic [2:0]                btn_i;
	logic [3:0]                pcb_revision_i;
	soc_csr_pkg::csr_word_t    wb_dat_o;
	logic                      wb_ack_o;
	soc_sysctl_pkg::gpio_out_t led_o;
	logic                      gpio_irq_o;
	logic                      timer_irq_o;
	logic                      flash_rst_n_o;
	logic                      periph_rst_n_o;
	int                        stim_lines;

	soc_top u_dut (
		.sys_clk        (sys_clk),
		.trigger_reset  (trigger_reset),
		.wb_adr_i       (wb_adr_i),
		.wb_dat_i       (wb_dat_i),
		.wb_we_i        (wb_we_i),
		.wb_cyc_i       (wb_cyc_i),
		.wb_stb_i       (wb_stb_i),
		.btn_i          (btn_i),
		.pcb_revision_i (pcb_revision_i),
		.wb_dat_o       (wb_dat_o),
		.wb_ack_o       (wb_ack_o),
		.led_o          (led_o),
		.gpio_irq_o     (gpio_irq_o),
		.timer_irq_o    (timer_irq_o),
		.flash_rst_n_o  (flash_rst_n_o),
		.periph_rst_n_o (periph_rst_n_o)
	);

	// 100 MHz
	always #5 sys_clk = ~sys_clk;

	// ----------------------------------------------------------
	// Failure and compare helpers
	// ----------------------------------------------------------
	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_word(input string name, input soc_csr_pkg::csr_word_t exp,
		input soc_csr_pkg::csr_word_t act);
		if (act !== exp) begin
			stop_run($sformatf("ERROR %s expected 0x%08h actual 0x%08h", name, exp, act));
		end
	endtask

	task automatic check_leds(input string name, input soc_sysctl_pkg::gpio_out_t exp,
		input soc_sysctl_pkg::gpio_out_t act);
		if (act !== exp) begin
			stop_run($sformatf("ERROR %s expected %b actual %b", name, exp, act));
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			stop_run($sformatf("ERROR %s expected %b actual %b", name, exp, act));
		end
	endtask

	// ----------------------------------------------------------
	// Wishbone master
	// ----------------------------------------------------------
	// Bank and register to byte address
	function automatic logic [`SOC_DATA_W-1:0] reg_addr(input int bank, input int idx);
		soc_csr_pkg::csr_addr_u a;
		a.sel.bank  = `SOC_CSR_BANK_W'(bank);
		a.sel.index = `SOC_CSR_REG_W'(idx);
		return `SOC_DATA_W'({a.raw, 2'b00});
	endfunction

	task automatic bus_access(input logic we, input int bank, input int idx,
		input soc_csr_pkg::csr_word_t wdata, output soc_csr_pkg::csr_word_t rdata);
		int waited;
		waited = 0;
		@(negedge sys_clk);
		wb_adr_i = reg_addr(bank, idx);
		wb_dat_i = wdata;
		wb_we_i  = we;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		while (!wb_ack_o && waited < ACK_LIMIT) begin
			@(negedge sys_clk);
			waited++;
		end
		if (!wb_ack_o) begin
			stop_run("No Wishbone acknowledge arrived within the bus time limit");
		end
		// Strobe stays up through the ack cycle, drop it in the cycle after ack
		rdata = wb_dat_o;
		@(negedge sys_clk);
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
	endtask

	task automatic write_reg(input int bank, input int idx, input soc_csr_pkg::csr_word_t data);
		soc_csr_pkg::csr_word_t unused;
		bus_access(1'b1, bank, idx, data, unused);
	endtask

	task automatic read_reg(input int bank, input int idx, output soc_csr_pkg::csr_word_t data);
		bus_access(1'b0, bank, idx, '0, data);
	endtask

	// ----------------------------------------------------------
	// Test steps
	// ----------------------------------------------------------
	task automatic set_inputs(input logic [2:0] btn, input logic [3:0] rev);
		@(negedge sys_clk);
		btn_i          = btn;
		pcb_revision_i = rev;
		// Two sync stages, history stage, pending register
		repeat (5) @(negedge sys_clk);
	endtask

	task automatic led_test(input int count, input string name);
		soc_csr_pkg::csr_word_t    rd;
		soc_sysctl_pkg::gpio_out_t val;
		repeat (count) begin
			val = soc_sysctl_pkg::gpio_out_t'($urandom);
			write_reg(SYS, `SOC_REG_GPIO_OUT, soc_csr_pkg::csr_word_t'(val));
			read_reg(SYS, `SOC_REG_GPIO_OUT, rd);
			check_word({name, " readback"}, soc_csr_pkg::csr_word_t'(val), rd);
			check_leds({name, " pins"}, val, led_o);
		end
	endtask

	// Stop first so no match can meet the pending clear
	task automatic stop_timer(input string name);
		write_reg(SYS, `SOC_REG_TIMER_CTRL, '0);
		write_reg(SYS, `SOC_REG_TIMER_CTRL, T_PEND);
		check_level({name, " irq after stop"}, 1'b0, timer_irq_o);
	endtask

	task automatic wait_timer_irq(input int limit, input string name);
		int waited;
		waited = 0;
		while (!timer_irq_o && waited < limit + 20) begin
			@(negedge sys_clk);
			waited++;
		end
		if (!timer_irq_o) begin
			stop_run($sformatf("%s timer interrupt never rose", name));
		end
	endtask

	task automatic timer_test(input logic auto_mode, input string name);
		soc_csr_pkg::csr_word_t rd;
		soc_csr_pkg::csr_word_t cmp;
		soc_csr_pkg::csr_word_t run_bits;
		cmp      = 4 + ($urandom % 37);
		run_bits = auto_mode ? (T_EN | T_AUTO) : T_EN;
		stop_timer(name);
		write_reg(SYS, `SOC_REG_TIMER_COMPARE, cmp);
		write_reg(SYS, `SOC_REG_TIMER_COUNTER, '0);
		write_reg(SYS, `SOC_REG_TIMER_CTRL, run_bits);
		wait_timer_irq(cmp, name);
		if (!auto_mode) begin
			// Parked on compare, enable dropped
			read_reg(SYS, `SOC_REG_TIMER_COUNTER, rd);
			check_word({name, " counter"}, cmp, rd);
			read_reg(SYS, `SOC_REG_TIMER_CTRL, rd);
			check_word({name, " ctrl"}, T_PEND, rd);
			write_reg(SYS, `SOC_REG_TIMER_CTRL, T_PEND);
			check_level({name, " irq clear"}, 1'b0, timer_irq_o);
		end else begin
			// Count wrapped to zero at the match edge, read samples it two cycles on
			read_reg(SYS, `SOC_REG_TIMER_COUNTER, rd);
			check_word({name, " restart"}, 2, rd);
			read_reg(SYS, `SOC_REG_TIMER_CTRL, rd);
			check_word({name, " ctrl"}, run_bits | T_PEND, rd);
			// Pause and clear, then run again for a second match
			write_reg(SYS, `SOC_REG_TIMER_CTRL, T_AUTO);
			write_reg(SYS, `SOC_REG_TIMER_CTRL, T_AUTO | T_PEND);
			check_level({name, " irq clear"}, 1'b0, timer_irq_o);
			write_reg(SYS, `SOC_REG_TIMER_CTRL, run_bits);
			wait_timer_irq(cmp, name);
			read_reg(SYS, `SOC_REG_TIMER_CTRL, rd);
			check_word({name, " ctrl again"}, run_bits | T_PEND, rd);
		end
		stop_timer(name);
	endtask

	task automatic hard_reset_test(input logic chord);
		int waited;
		waited = 0;
		if (chord) begin
			@(negedge sys_clk);
			btn_i = 3'b111;
		end else begin
			write_reg(SYS, `SOC_REG_HARD_RESET, soc_csr_pkg::csr_word_t'($urandom));
		end
		while (periph_rst_n_o && waited < ACK_LIMIT) begin
			@(negedge sys_clk);
			waited++;
		end
		if (periph_rst_n_o) begin
			stop_run("Peripheral reset did not assert after the hard reset request");
		end
		btn_i = 3'b000;
	endtask

	// Flash leaves reset first, system within hold plus two cycles
	task automatic wait_release(input string name);
		int   cycles;
		logic flash_first;
		cycles      = 0;
		flash_first = 1'b0;
		while (!periph_rst_n_o && cycles < HOLD + 2) begin
			@(negedge sys_clk);
			cycles++;
			if (flash_rst_n_o && !periph_rst_n_o) begin
				flash_first = 1'b1;
			end
		end
		check_level({name, " periph release"}, 1'b1, periph_rst_n_o);
		check_level({name, " flash release"}, 1'b1, flash_rst_n_o);
		check_level({name, " flash first"}, 1'b1, flash_first);
	endtask

	function automatic int count_lines();
		int    fd;
		int    n;
		string text;
		n  = 0;
		fd = $fopen(STIM_FILE, "r");
		if (fd != 0) begin
			while ($fgets(text, fd) != 0) begin
				n++;
			end
			$fclose(fd);
		end
		return n;
	endfunction

	// ----------------------------------------------------------
	// Command loop
	// ----------------------------------------------------------
	initial begin
		int                     fd;
		int                     code;
		int                     step;
		int                     bank;
		int                     idx;
		int                     val;
		byte                    cmd;
		soc_csr_pkg::csr_word_t data;
		soc_csr_pkg::csr_word_t rd;
		string                  name;
		string                  text;
		sys_clk        = 1'b0;
		trigger_reset  = 1'b1;
		wb_adr_i       = '0;
		wb_dat_i       = '0;
		wb_we_i        = 1'b0;
		wb_cyc_i       = 1'b0;
		wb_stb_i       = 1'b0;
		btn_i          = 3'b000;
		pcb_revision_i = 4'h0;
		void'($urandom(79843));
		stim_lines = count_lines();
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			stop_run("Could not open the stimulus file");
		end
		repeat (10) @(negedge sys_clk);
		trigger_reset = 1'b0;
		step = 0;
		while ($fscanf(fd, " %c", cmd) == 1) begin
			step++;
			name = $sformatf("step %0d (%c)", step, cmd);
			case (cmd)
				"#": code = $fgets(text, fd);
				"w": begin
					code = $fscanf(fd, "%d %d %h", bank, idx, data);
					write_reg(bank, idx, data);
				end
				"r": begin
					code = $fscanf(fd, "%d %d %h", bank, idx, data);
					read_reg(bank, idx, rd);
					check_word(name, data, rd);
				end
				"o": begin
					code = $fscanf(fd, "%d", val);
					led_test(val, name);
				end
				"l": begin
					code = $fscanf(fd, "%h", val);
					check_leds(name, soc_sysctl_pkg::gpio_out_t'(val), led_o);
				end
				"g": begin
					code = $fscanf(fd, "%h %h", bank, idx);
					set_inputs(3'(bank), 4'(idx));
				end
				"i": begin
					code = $fscanf(fd, "%d", val);
					check_level(name, val[0], gpio_irq_o);
				end
				"t": begin
					code = $fscanf(fd, "%d", val);
					timer_test(val[0], name);
				end
				"h": begin
					code = $fscanf(fd, "%d", val);
					hard_reset_test(val[0]);
				end
				"x": wait_release(name);
				default: stop_run($sformatf("Unknown stimulus command %c", cmd));
			endcase
		end
		$fclose(fd);
		$display("Everything OK");
		$finish;
	end

	// Watchdog, 500 cycles per stim line plus the reset hold
	initial begin
		wait (stim_lines > 0);
		repeat (stim_lines * 500 + HOLD) @(posedge sys_clk);
		stop_run("Timeout: the run did not finish in the expected number of cycles");
	end

endmodule

//--- project.f
+incdir+include
src/soc_csr_pkg.sv
src/soc_sysctl_pkg.sv
src/reset_sequencer.sv
src/wb_csr_bridge.sv
src/gpio_input_sync.sv
src/sysctl_timer.sv
src/sysctl_regs.sv
src/soc_top.sv
tb/tb_soc_top.sv

//--- tb/soc_stim.txt
# Board control core stimulus, one command per line, numbers in hex except bank and reg
# w bank reg data | r bank reg expect | o count | l leds | g btn rev | i irq | t auto | h chord | x
x
r 1 0 10004d31
r 1 8 00000000
o 6
w 1 2 1
w 3 2 2
r 3 2 00000000
r 0 0 00000000
r 1 2 00000001
l 1
r 1 1 00000000
g 0 a
r 1 1 00000050
r 1 4 00000000
i 0
w 1 3 01
g 1 a
r 1 1 00000051
i 1
r 1 4 00000001
w 1 4 01
i 0
g 3 a
i 0
r 1 4 00000000
g 0 a
i 1
w 1 4 7f
i 0
t 0
t 1
w 1 2 3
h 0
x
r 1 2 00000000
l 0
w 1 2 2
h 1
x
l 0
r 1 0 10004d31
